// ==== Makefile ====
# Verilator build and run for the lite SMC testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := smc_lite_tb
FILELIST  := smc_lite.f
BUILD_DIR := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/smc_clk_gen.sv ====
// Clock and reset source for the SMC testbench
// Free-running pclk and an active-low reset held for a set number of cycles
`timescale 1ns/1ps

module smc_clk_gen #(
  parameter int PERIOD_NS    = 40,  // Clock period
  parameter int RESET_CYCLES = 10   // Cycles with arst_n low
) (
  output logic pclk,
  output logic arst_n
);

  initial
  begin
    pclk = 1'b0;
    forever #(PERIOD_NS / 2) pclk = ~pclk;
  end

  // Release on a rising edge, DUT sees it one edge later
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge pclk);
    arst_n <= 1'b1;
  end

endmodule

// ==== dv/smc_lite_tb.sv ====
// Directed testbench for the lite SMC
// Drives APB and host ports of smc_lite, models a 256-word async SRAM
// and checks register map, strobe widths, hold gap, overrun and config timing
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_lite_tb;

  import smc_reg_pkg::*;
  import smc_mem_pkg::*;

  localparam int CLK_PERIOD_NS = 40;
  localparam int N_READS       = 6;
  localparam int N_WRITES      = 6;
  localparam int ACCESS_CYCLES = 24;  // ws 15 + hold 3 + req setup and idle
  localparam int APB_CYCLES    = 4;
  localparam int N_ACCESSES    = N_READS + N_WRITES + 6;
  localparam int N_APB         = N_READS + N_WRITES + 20;
  localparam int QUIET_CYCLES  = 20;  // Window with no stray done
  localparam int ACCESS_LIMIT  = 40;
  localparam int IDLE_LIMIT    = 10;
  localparam int WATCHDOG_CYCLES = 10 + N_ACCESSES * ACCESS_CYCLES
                                 + N_APB * APB_CYCLES + QUIET_CYCLES + 200;

  logic                       pclk;
  logic                       arst_n;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`SMC_APB_ADDR_W-1:0] paddr;
  logic [`SMC_DATA_W-1:0]     pwdata;
  logic [`SMC_DATA_W-1:0]     prdata;
  logic                       req;
  logic                       req_write;
  logic [`SMC_MEM_ADDR_W-1:0] req_addr;
  logic [`SMC_DATA_W-1:0]     req_wdata;
  logic                       done;
  logic [`SMC_DATA_W-1:0]     rdata;
  logic                       busy;
  logic                       mem_cs_n;
  logic                       mem_oe_n;
  logic                       mem_we_n;
  logic [`SMC_MEM_ADDR_W-1:0] mem_addr;
  logic [`SMC_DATA_W-1:0]     mem_wdata;
  logic [`SMC_DATA_W-1:0]     mem_rdata;
  logic [`SMC_DATA_W-1:0]     mem [0:255];   // SRAM model array
  logic [31:0]                lfsr_q = 32'h70d5ed23;

  smc_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) i_clk_gen (
    .pclk(pclk), .arst_n(arst_n)
  );

  smc_lite i_smc_lite (
    .pclk(pclk), .arst_n(arst_n), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .req(req), .req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
    .done(done), .rdata(rdata), .busy(busy), .mem_cs_n(mem_cs_n),
    .mem_oe_n(mem_oe_n), .mem_we_n(mem_we_n), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

  // ------------------------------------------------------------
  // SRAM model, low 8 address bits
  // ------------------------------------------------------------
  assign mem_rdata = (!mem_oe_n && !mem_cs_n) ? mem[mem_addr[7:0]] : '0;

  always @(posedge mem_we_n)
    if (arst_n)
      mem[mem_addr[7:0]] = mem_wdata;  // Write on WE rising edge

  // ------------------------------------------------------------
  // Random source and error handling
  // ------------------------------------------------------------
  function automatic logic lfsr_next_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);  // Galois taps
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], lfsr_next_bit()};  // One step per bit
    return r;
  endfunction

  // Config word per register map: hold 9:8, ws_write 7:4, ws_read 3:0
  function automatic logic [31:0] cfg_word(input smc_ws_t ws_r, input smc_ws_t ws_w,
                                           input smc_hold_t hd);
    return {22'd0, hd, ws_w, ws_r};
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0d ns: %s actual 0x%08h expected 0x%08h",
               $time, name, actual, expected);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------
  // Bus tasks
  // ------------------------------------------------------------
  task automatic apb_write(input logic [`SMC_APB_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;   // Setup phase
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;   // Access phase
    @(posedge pclk);   // Write taken here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [`SMC_APB_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    data = prdata;     // Mid-cycle, prdata settled
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // One-cycle req, returns right after the edge that samples it
  task automatic issue_req(input smc_op_e op, input logic [15:0] addr, input logic [31:0] wdata);
    @(posedge pclk);
    req       <= 1'b1;
    req_write <= (op == OP_WRITE);
    req_addr  <= addr;
    req_wdata <= wdata;
    @(posedge pclk);
    req       <= 1'b0;
  endtask

  // Counts strobe-low cycles and edges until done, sampled at falling edges
  task automatic wait_done(output logic [31:0] rd, output int lat, output int oe_low,
                           output int we_low);
    lat    = 0;
    oe_low = 0;
    we_low = 0;
    @(negedge pclk);
    while (!done)
    begin
      check_value("mem_cs_n in strobe window", 32'(mem_cs_n), 32'd0);
      if (!mem_oe_n)
        oe_low++;
      if (!mem_we_n)
        we_low++;
      lat++;
      if (lat > ACCESS_LIMIT)
        report_error("done did not arrive after a host request");
      @(negedge pclk);
    end
    // CS, OE and WE all high once the window has closed
    check_value("strobes after access", 32'({mem_cs_n, mem_oe_n, mem_we_n}), 32'h7);
    rd = rdata;
  endtask

  task automatic wait_idle();
    int guard;
    guard = 0;
    while (busy)
    begin
      guard++;
      if (guard > IDLE_LIMIT)
        report_error("busy did not fall after the access");
      @(negedge pclk);
    end
  endtask

  task automatic host_read(input logic [15:0] addr, output logic [31:0] rd, output int lat,
                           output int oe_low, output int we_low);
    issue_req(OP_READ, addr, '0);
    wait_done(rd, lat, oe_low, we_low);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [31:0] data, output int lat,
                            output int oe_low, output int we_low);
    logic [31:0] unused_rd;
    issue_req(OP_WRITE, addr, data);
    wait_done(unused_rd, lat, oe_low, we_low);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic reset_and_regmap();
    logic [31:0] rd;
    logic [31:0] wval;
    @(negedge pclk);
    check_value("mem_cs_n after reset", 32'(mem_cs_n), 32'd1);
    check_value("mem_oe_n after reset", 32'(mem_oe_n), 32'd1);
    check_value("mem_we_n after reset", 32'(mem_we_n), 32'd1);
    check_value("done after reset", 32'(done), 32'd0);
    check_value("busy after reset", 32'(busy), 32'd0);
    apb_read(REG_CONFIG, rd);
    check_value("config after reset", rd, `SMC_CFG_RESET);
    apb_read(REG_STATUS, rd);
    check_value("status after reset", rd, 32'h0);
    apb_read(5'h08, rd);
    check_value("unmapped 0x08", rd, 32'h0);
    apb_read(5'h1c, rd);
    check_value("unmapped 0x1c", rd, 32'h0);
    wval = rand_bits(32);
    apb_write(REG_CONFIG, wval);
    apb_read(REG_CONFIG, rd);
    check_value("config readback", rd, wval & 32'h0000_03ff);  // Only 9:0 kept
  endtask

  task automatic read_access();
    smc_ws_t     ws;
    logic [15:0] addr;
    logic [31:0] rd;
    int          lat;
    int          oe_low;
    int          we_low;
    for (int i = 0; i < N_READS; i++)
    begin
      ws   = (i == 0) ? 4'd0 : (i == 1) ? 4'd15 : 4'(rand_bits(4));  // Both ends first
      addr = 16'(rand_bits(16));
      apb_write(REG_CONFIG, cfg_word(ws, 4'd2, 2'd0));
      host_read(addr, rd, lat, oe_low, we_low);
      check_value("rdata", rd, mem[addr[7:0]]);
      check_value("read latency", 32'(lat), 32'(ws) + 1);
      check_value("mem_oe_n low cycles", 32'(oe_low), 32'(ws) + 1);
      check_value("mem_we_n low cycles on read", 32'(we_low), 32'd0);
      wait_idle();
    end
  endtask

  task automatic write_access();
    smc_ws_t     ws;
    logic [15:0] addr;
    logic [31:0] data;
    int          lat;
    int          oe_low;
    int          we_low;
    for (int i = 0; i < N_WRITES; i++)
    begin
      ws   = (i == 0) ? 4'd0 : 4'(rand_bits(4));
      addr = 16'(rand_bits(16));
      data = rand_bits(32);
      apb_write(REG_CONFIG, cfg_word(4'd3, ws, 2'd0));
      host_write(addr, data, lat, oe_low, we_low);
      check_value("write latency", 32'(lat), 32'(ws) + 1);
      check_value("mem_we_n low cycles", 32'(we_low), 32'(ws) + 1);
      check_value("mem_oe_n low cycles on write", 32'(oe_low), 32'd0);
      wait_idle();
      check_value("model word after write", mem[addr[7:0]], data);
    end
  endtask

  task automatic hold_gap();
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    int          lat;
    int          oe_low;
    int          we_low;
    addr = 16'(rand_bits(16));
    data = rand_bits(32);
    apb_write(REG_CONFIG, cfg_word(4'd1, 4'd1, 2'd3));
    host_write(addr, data, lat, oe_low, we_low);
    // Busy for 3 cycles from the done cycle on
    for (int i = 0; i < 3; i++)
    begin
      if (i > 0)
        @(negedge pclk);
      check_value("busy during hold", 32'(busy), 32'd1);
    end
    @(posedge pclk);   // Edge where busy falls
    req       <= 1'b1;
    req_write <= 1'b0;
    req_addr  <= addr;
    @(negedge pclk);
    check_value("busy after hold", 32'(busy), 32'd0);
    @(posedge pclk);   // First edge after busy fell, req sampled
    req       <= 1'b0;
    wait_done(rd, lat, oe_low, we_low);
    check_value("read after hold latency", 32'(lat), 32'd2);
    check_value("read after hold data", rd, data);
    wait_idle();
    apb_read(REG_STATUS, rd);
    check_value("status after hold", rd, 32'h0);  // No overrun
  endtask

  task automatic overrun_drop();
    logic [15:0] addr_a;
    logic [15:0] addr_b;
    logic [31:0] saved;
    logic [31:0] rd;
    int          lat;
    int          oe_low;
    int          we_low;
    addr_a = 16'(rand_bits(16));
    addr_b = addr_a ^ 16'h0080;  // Different model word
    saved  = mem[addr_a[7:0]];
    apb_write(REG_CONFIG, cfg_word(4'd5, 4'd2, 2'd0));
    issue_req(OP_READ, addr_b, '0);
    issue_req(OP_WRITE, addr_a, ~saved);  // Lands while busy
    apb_read(REG_STATUS, rd);             // Still inside the OE window
    check_value("status busy and overrun", rd, 32'h3);
    wait_done(rd, lat, oe_low, we_low);
    check_value("rdata with overrun", rd, mem[addr_b[7:0]]);
    for (int i = 0; i < QUIET_CYCLES; i++)
    begin
      @(negedge pclk);
      check_value("extra done", 32'(done), 32'd0);
    end
    check_value("model word after dropped write", mem[addr_a[7:0]], saved);
    wait_idle();
    apb_read(REG_STATUS, rd);
    check_value("status overrun set", rd, 32'h2);
    apb_write(REG_STATUS, rand_bits(32));
    apb_read(REG_STATUS, rd);
    check_value("status overrun cleared", rd, 32'h0);
  endtask

  task automatic config_timing();
    logic [15:0] addr;
    logic [31:0] rd;
    int          lat;
    int          oe_low;
    int          we_low;
    addr = 16'(rand_bits(16));
    apb_write(REG_CONFIG, cfg_word(4'd4, 4'd2, 2'd0));
    fork
      host_read(addr, rd, lat, oe_low, we_low);
      begin
        repeat (2) @(posedge pclk);  // Start at the req sampling edge
        apb_write(REG_CONFIG, cfg_word(4'd9, 4'd2, 2'd0));
      end
    join
    check_value("oe width with mid-access config", 32'(oe_low), 32'd5);
    check_value("latency with mid-access config", 32'(lat), 32'd5);
    check_value("rdata with mid-access config", rd, mem[addr[7:0]]);
    wait_idle();
    host_read(addr, rd, lat, oe_low, we_low);
    check_value("oe width with new config", 32'(oe_low), 32'd10);
    check_value("latency with new config", 32'(lat), 32'd10);
    wait_idle();
  endtask

  // ------------------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------------------
  initial
  begin
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req       = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = rand_bits(32);      // Preload with LFSR data
    @(posedge arst_n);
    reset_and_regmap();
    read_access();
    write_access();
    hold_gap();
    overrun_drop();
    config_timing();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge pclk);
    report_error("watchdog expired before the tests finished");
  end

endmodule

// ==== logic/smc_access_fsm.sv ====
// External memory access sequencer
// Accepts single-cycle host strobes, drives CS/OE/WE for ws+1 cycles,
// then an optional hold gap. Requests seen while busy are dropped and
// flagged in the sticky overrun bit of the status word.
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_access_fsm (
  input  logic                       pclk,          // Clock
  input  logic                       arst_n,        // Async reset, active low
  input  logic                       req,           // Host request strobe
  input  logic                       req_write,     // 1 = write
  input  logic [`SMC_MEM_ADDR_W-1:0] req_addr,      // Host address
  input  logic [`SMC_DATA_W-1:0]     req_wdata,     // Host write data
  input  smc_reg_pkg::smc_ws_t       ws_read,       // Read wait states
  input  smc_reg_pkg::smc_ws_t       ws_write,      // Write wait states
  input  smc_reg_pkg::smc_hold_t     hold,          // Hold gap length
  input  logic [`SMC_DATA_W-1:0]     mem_rdata,     // Memory read data
  input  logic                       status_clr,    // Clear overrun
  output logic                       done,          // Access complete pulse
  output logic [`SMC_DATA_W-1:0]     rdata,         // Captured read data
  output logic                       busy,          // Sequencer not idle
  output logic [`SMC_DATA_W-1:0]     status_rdata,  // Status word
  output logic                       mem_cs_n,      // Chip select
  output logic                       mem_oe_n,      // Output enable
  output logic                       mem_we_n,      // Write enable
  output logic [`SMC_MEM_ADDR_W-1:0] mem_addr,      // Memory address
  output logic [`SMC_DATA_W-1:0]     mem_wdata      // Memory write data
);

  import smc_reg_pkg::*;
  import smc_mem_pkg::*;

  smc_state_e  state_q;
  smc_op_e     op_q;        // Direction of current access
  smc_ws_t     cnt_q;       // Wait and hold down-counter
  smc_hold_t   hold_q;      // Hold latched at accept
  logic        overrun_q;   // Sticky dropped-request flag
  logic        accept;      // Request taken this cycle
  logic        access_end;  // Last strobe cycle
  smc_status_t status;

  assign accept     = (state_q == ST_IDLE) & req;
  assign access_end = (state_q == ST_ACCESS) & (cnt_q == '0);
  assign busy       = (state_q != ST_IDLE);

  // ------------------------------------------------------------
  // State and counter
  // ------------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= ST_IDLE;
      op_q    <= OP_READ;
      cnt_q   <= '0;
      hold_q  <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
          if (req)
          begin
            state_q <= ST_ACCESS;
            op_q    <= req_write ? OP_WRITE : OP_READ;
            cnt_q   <= req_write ? ws_write : ws_read;  // Config frozen here
            hold_q  <= hold;
          end
        ST_ACCESS:
          if (cnt_q == '0)
          begin
            if (hold_q != '0)
            begin
              state_q <= ST_HOLD;
              cnt_q   <= {2'b00, hold_q} - 4'd1;
            end
            else
              state_q <= ST_IDLE;
          end
          else
            cnt_q <= cnt_q - 4'd1;
        ST_HOLD:
          if (cnt_q == '0)
            state_q <= ST_IDLE;            // Next req taken after this edge
          else
            cnt_q <= cnt_q - 4'd1;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Memory strobes, done and overrun
  // ------------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mem_cs_n  <= 1'b1;
      mem_oe_n  <= 1'b1;
      mem_we_n  <= 1'b1;
      done      <= 1'b0;
      overrun_q <= 1'b0;
    end
    else
    begin
      done <= access_end;                  // One cycle after strobe end
      if (accept)
      begin
        mem_cs_n <= 1'b0;
        mem_oe_n <= req_write;             // Low for read
        mem_we_n <= ~req_write;            // Low for write
      end
      else if (access_end)
      begin
        mem_cs_n <= 1'b1;
        mem_oe_n <= 1'b1;
        mem_we_n <= 1'b1;
      end
      if (req & busy)
        overrun_q <= 1'b1;                 // Set wins over clear
      else if (status_clr)
        overrun_q <= 1'b0;
    end
  end

  // Address, write data and read capture
  always_ff @(posedge pclk)
  begin
    if (accept)
    begin
      mem_addr  <= req_addr;
      mem_wdata <= req_wdata;
    end
    if (access_end && (op_q == OP_READ))
      rdata <= mem_rdata;                  // Sampled at end of OE window
  end

  always_comb
  begin
    status         = '0;
    status.busy    = busy;
    status.overrun = overrun_q;
  end

  assign status_rdata = status;

endmodule

// ==== logic/smc_apb_if.sv ====
// APB-lite slave front end of the SMC
// Decodes the register offset in the access phase, raises one-cycle write
// strobes for config and status, and muxes read data back onto prdata.
// Zero wait states, purely combinational.
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_apb_if (
  input  logic                        psel,          // APB select
  input  logic                        penable,       // Access phase
  input  logic                        pwrite,        // 1 = write
  input  smc_reg_pkg::smc_apb_addr_t  paddr,         // Register offset
  input  logic [`SMC_DATA_W-1:0]      pwdata,        // Write data
  input  logic [`SMC_DATA_W-1:0]      cfg_rdata,     // Config readback
  input  logic [`SMC_DATA_W-1:0]      status_rdata,  // Status readback
  output logic [`SMC_DATA_W-1:0]      prdata,        // APB read data
  output logic                        cfg_we,        // Config load strobe
  output logic                        status_clr     // Clears overrun
);

  import smc_reg_pkg::*;

  logic access;      // Access phase of a transfer
  logic sel_config;  // Config register selected
  logic sel_status;  // Status register selected
  logic wr_any;      // Write data on the bus, any offset

  assign access = psel & penable;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  always_comb
  begin
    sel_config = 1'b0;
    sel_status = 1'b0;
    if (access)
    begin
      case (paddr)
        REG_CONFIG: sel_config = 1'b1;
        REG_STATUS: sel_status = 1'b1;
        default:    ;                  // Unmapped offset
      endcase
    end
  end

  // One-cycle write strobes, data is don't-care for status
  assign wr_any     = access & pwrite;
  assign cfg_we     = sel_config & wr_any;
  assign status_clr = sel_status & wr_any;

  // ------------------------------------------------------------
  // Read data mux
  // ------------------------------------------------------------
  always_comb
  begin
    prdata = '0;                       // Zero outside access and unmapped
    if (sel_config)
      prdata = cfg_rdata;
    else if (sel_status)
      prdata = status_rdata;
  end

endmodule

// ==== logic/smc_cfreg.sv ====
// Configuration register of the SMC
// Holds read/write wait states and hold gap, loads from pwdata on cfg_we
// and feeds the fields to the access sequencer. Unused bits read zero.
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_cfreg (
  input  logic                     pclk,       // APB clock
  input  logic                     arst_n,     // Async reset, active low
  input  logic                     cfg_we,     // Load strobe from APB decode
  input  logic [`SMC_DATA_W-1:0]   pwdata,     // APB write data
  output logic [`SMC_DATA_W-1:0]   cfg_rdata,  // Packed readback
  output smc_reg_pkg::smc_ws_t     ws_read,    // Read wait states
  output smc_reg_pkg::smc_ws_t     ws_write,   // Write wait states
  output smc_reg_pkg::smc_hold_t   hold        // Hold gap cycles
);

  import smc_reg_pkg::*;

  smc_cfg_t  cfg_rst;     // Reset value split into fields
  smc_cfg_t  cfg_wr;      // pwdata viewed as config word
  smc_cfg_t  cfg_rd;      // Readback word
  smc_ws_t   ws_read_q;
  smc_ws_t   ws_write_q;
  smc_hold_t hold_q;

  assign cfg_rst = smc_cfg_t'(`SMC_CFG_RESET);
  assign cfg_wr  = smc_cfg_t'(pwdata);

  // ------------------------------------------------------------
  // Field registers
  // ------------------------------------------------------------
  always_ff @(posedge pclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ws_read_q  <= cfg_rst.ws_read;
      ws_write_q <= cfg_rst.ws_write;
      hold_q     <= cfg_rst.hold;
    end
    else if (cfg_we)
    begin
      ws_read_q  <= cfg_wr.ws_read;    // Bits 3:0
      ws_write_q <= cfg_wr.ws_write;   // Bits 7:4
      hold_q     <= cfg_wr.hold;       // Bits 9:8
    end
  end

  // Readback, reserved bits forced low
  always_comb
  begin
    cfg_rd          = '0;
    cfg_rd.ws_read  = ws_read_q;
    cfg_rd.ws_write = ws_write_q;
    cfg_rd.hold     = hold_q;
  end

  assign cfg_rdata = cfg_rd;
  assign ws_read   = ws_read_q;
  assign ws_write  = ws_write_q;
  assign hold      = hold_q;

endmodule

// ==== logic/smc_defines.svh ====
// Global widths and reset constants for the lite static memory controller
// Include in any RTL or testbench file that sizes buses or checks config
`ifndef SMC_DEFINES_SVH
`define SMC_DEFINES_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define SMC_DATA_W      32   // APB and memory data
`define SMC_MEM_ADDR_W  16   // External memory address
`define SMC_APB_ADDR_W  5    // APB register offset

// ------------------------------------------------------------
// Configuration reset value
// ------------------------------------------------------------
// Read ws 3, write ws 2, hold 1
`define SMC_CFG_RESET   32'h0000_0123

`endif

// ==== logic/smc_lite.sv ====
// Top level of the lite static memory controller
// APB-lite config port, single-strobe host port, one async SRAM/flash
// device. Connects APB decode, config register and access sequencer.
`timescale 1ns/1ps
`include "smc_defines.svh"

module smc_lite (
  input  logic                        pclk,         // Clock
  input  logic                        arst_n,       // Async reset, active low
  // APB-lite
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  smc_reg_pkg::smc_apb_addr_t  paddr,
  input  logic [`SMC_DATA_W-1:0]      pwdata,
  output logic [`SMC_DATA_W-1:0]      prdata,
  // Host
  input  logic                        req,
  input  logic                        req_write,
  input  logic [`SMC_MEM_ADDR_W-1:0]  req_addr,
  input  logic [`SMC_DATA_W-1:0]      req_wdata,
  output logic                        done,
  output logic [`SMC_DATA_W-1:0]      rdata,
  output logic                        busy,
  // External memory
  output logic                        mem_cs_n,
  output logic                        mem_oe_n,
  output logic                        mem_we_n,
  output logic [`SMC_MEM_ADDR_W-1:0]  mem_addr,
  output logic [`SMC_DATA_W-1:0]      mem_wdata,
  input  logic [`SMC_DATA_W-1:0]      mem_rdata
);

  import smc_reg_pkg::*;

  logic                   cfg_we;        // APB to config
  logic                   status_clr;    // APB to sequencer
  logic [`SMC_DATA_W-1:0] cfg_rdata;
  logic [`SMC_DATA_W-1:0] status_rdata;
  smc_ws_t                ws_read;       // Config fields to sequencer
  smc_ws_t                ws_write;
  smc_hold_t              hold;

  smc_apb_if i_apb_if (
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .cfg_rdata(cfg_rdata), .status_rdata(status_rdata),
    .prdata(prdata), .cfg_we(cfg_we), .status_clr(status_clr)
  );

  smc_cfreg i_cfreg (
    .pclk(pclk), .arst_n(arst_n), .cfg_we(cfg_we), .pwdata(pwdata),
    .cfg_rdata(cfg_rdata), .ws_read(ws_read), .ws_write(ws_write), .hold(hold)
  );

  smc_access_fsm i_access_fsm (
    .pclk(pclk), .arst_n(arst_n), .req(req), .req_write(req_write),
    .req_addr(req_addr), .req_wdata(req_wdata), .ws_read(ws_read),
    .ws_write(ws_write), .hold(hold), .mem_rdata(mem_rdata),
    .status_clr(status_clr), .done(done), .rdata(rdata), .busy(busy),
    .status_rdata(status_rdata), .mem_cs_n(mem_cs_n), .mem_oe_n(mem_oe_n),
    .mem_we_n(mem_we_n), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

endmodule

// ==== logic/smc_mem_pkg.sv ====
// Memory-side types for the lite SMC
// Sequencer states and the access direction latched per request

package smc_mem_pkg;

  // ------------------------------------------------------------
  // Access sequencer states
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // Waiting for host req
    ST_ACCESS = 2'd1,  // Strobes active, counting wait states
    ST_HOLD   = 2'd2   // Strobes high, hold gap before next req
  } smc_state_e;

  // ------------------------------------------------------------
  // Access opcode
  // ------------------------------------------------------------
  typedef enum logic {
    OP_READ  = 1'b0,  // OE strobe
    OP_WRITE = 1'b1   // WE strobe
  } smc_op_e;

endpackage

// ==== logic/smc_reg_pkg.sv ====
// Register-side types for the lite SMC
// Register map offsets, config field types and the config/status word layouts
`include "smc_defines.svh"

package smc_reg_pkg;

  typedef logic [`SMC_APB_ADDR_W-1:0] smc_apb_addr_t;  // APB register offset

  // Register map
  typedef enum smc_apb_addr_t {
    REG_CONFIG = 5'h00,  // Wait states and hold
    REG_STATUS = 5'h04   // Busy and sticky overrun
  } smc_reg_addr_e;

  typedef logic [3:0] smc_ws_t;    // Extra strobe cycles, 0..15
  typedef logic [1:0] smc_hold_t;  // Idle gap after access, 0..3

  // Config word, bits 9:0 used, the rest reads zero
  typedef struct packed {
    logic [`SMC_DATA_W-11:0] rsvd;
    smc_hold_t               hold;      // 9:8
    smc_ws_t                 ws_write;  // 7:4
    smc_ws_t                 ws_read;   // 3:0
  } smc_cfg_t;

  // Status word
  typedef struct packed {
    logic [`SMC_DATA_W-3:0] rsvd;
    logic                   overrun;  // Bit 1, sticky
    logic                   busy;     // Bit 0
  } smc_status_t;

endpackage

// ==== smc_lite.f ====
+incdir+logic
logic/smc_reg_pkg.sv
logic/smc_mem_pkg.sv
logic/smc_apb_if.sv
logic/smc_cfreg.sv
logic/smc_access_fsm.sv
logic/smc_lite.sv
dv/smc_clk_gen.sv
dv/smc_lite_tb.sv
